/* rtl/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // register file sizes
    localparam int PRF_NUM  = 64;
    localparam int PRF_W    = 6;
    localparam int ARCH_NUM = 32;
    localparam int ARCH_W   = 5;

    // busy bitmap out of reset, 0..ARCH_NUM-1 hold the identity mappings
    localparam logic [PRF_NUM-1:0] BUSY_RST = {
        {(PRF_NUM - ARCH_NUM){1'b0}},
        {ARCH_NUM{1'b1}}
    };

    typedef logic [PRF_W-1:0]  prf_num_t;   // physical register index
    typedef logic [ARCH_W-1:0] arch_reg_t;  // architectural register index

endpackage

`default_nettype wire

/* rtl/alloc_if.sv */
`default_nettype none

interface alloc_if;

    logic                 req_0;   // slot 0 wants a new register
    logic                 req_1;
    rename_pkg::prf_num_t prf_0;   // granted registers
    rename_pkg::prf_num_t prf_1;
    logic                 ready;   // every requesting slot can be served

    modport requester (
        output req_0, req_1,
        input  prf_0, prf_1, ready
    );

    modport provider (
        input  req_0, req_1,
        output prf_0, prf_1, ready
    );

endinterface

`default_nettype wire

/* rtl/commit_if.sv */
`default_nettype none

interface commit_if;

    // slot 0 is older in program order
    logic                  valid_0;
    logic                  wr_0;
    rename_pkg::arch_reg_t arch_0;
    rename_pkg::prf_num_t  prf_0;    // committed mapping
    rename_pkg::prf_num_t  stale_0;  // mapping released by this commit

    logic                  valid_1;
    logic                  wr_1;
    rename_pkg::arch_reg_t arch_1;
    rename_pkg::prf_num_t  prf_1;
    rename_pkg::prf_num_t  stale_1;

    modport source (
        output valid_0, wr_0, arch_0, prf_0, stale_0,
        output valid_1, wr_1, arch_1, prf_1, stale_1
    );

    modport sink (
        input valid_0, wr_0, arch_0, prf_0, stale_0,
        input valid_1, wr_1, arch_1, prf_1, stale_1
    );

endinterface

`default_nettype wire

/* rtl/prf_free_enc.sv */
`default_nettype none

module prf_free_enc (
    input  wire logic [rename_pkg::PRF_NUM-1:0] busy,
    output logic                                found,
    output rename_pkg::prf_num_t                idx
);

    // scan from the top so the lowest clear bit is the last one kept
    always_comb begin
        found = 1'b0;
        idx   = '0;
        for (int i = rename_pkg::PRF_NUM - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                found = 1'b1;
                idx   = rename_pkg::prf_num_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/free_list.sv */
`default_nettype none

module free_list (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   recover,
    input  wire logic   pause,
    alloc_if.provider   alloc,
    commit_if.sink      cmt
);

    localparam logic [rename_pkg::PRF_NUM-1:0] BIT0 = rename_pkg::PRF_NUM'(1);

    logic [rename_pkg::PRF_NUM-1:0] spec_busy;  // 1 = taken
    logic [rename_pkg::PRF_NUM-1:0] cmt_busy;   // as of the last commit
    logic [rename_pkg::PRF_NUM-1:0] busy_1;     // spec_busy with grant 0 taken out
    logic [rename_pkg::PRF_NUM-1:0] alloc_mask;
    logic [rename_pkg::PRF_NUM-1:0] free_mask;
    logic [rename_pkg::PRF_NUM-1:0] spec_next;
    logic [rename_pkg::PRF_NUM-1:0] cmt_next;

    logic                 found_0;
    logic                 found_1;
    rename_pkg::prf_num_t idx_0;
    rename_pkg::prf_num_t idx_1;
    logic                 fire;
    logic                 cmt_wr_0;
    logic                 cmt_wr_1;

    function automatic logic [rename_pkg::PRF_NUM-1:0] onehot(input rename_pkg::prf_num_t p);
        logic [rename_pkg::PRF_NUM-1:0] v;
        v    = '0;
        v[p] = 1'b1;
        return v;
    endfunction

    prf_free_enc i_enc_0 (
        .busy  (spec_busy),
        .found (found_0),
        .idx   (idx_0)
    );

    assign busy_1 = alloc.req_0 ? (spec_busy | onehot(idx_0)) : spec_busy;

    prf_free_enc i_enc_1 (
        .busy  (busy_1),
        .found (found_1),
        .idx   (idx_1)
    );

    assign alloc.prf_0 = idx_0;
    assign alloc.prf_1 = idx_1;
    assign alloc.ready = (!alloc.req_0 || found_0) && (!alloc.req_1 || found_1);

    assign fire     = alloc.ready && !pause && !recover;
    assign cmt_wr_0 = cmt.valid_0 && cmt.wr_0;
    assign cmt_wr_1 = cmt.valid_1 && cmt.wr_1;

    always_comb begin
        alloc_mask = '0;
        if (fire && alloc.req_0) alloc_mask = alloc_mask | onehot(idx_0);
        if (fire && alloc.req_1) alloc_mask = alloc_mask | onehot(idx_1);

        free_mask = '0;
        if (cmt_wr_0) free_mask = free_mask | onehot(cmt.stale_0);
        if (cmt_wr_1) free_mask = free_mask | onehot(cmt.stale_1);

        // committed side in program order, slot 1 may release slot 0's register
        cmt_next = cmt_busy;
        if (cmt_wr_0) cmt_next = (cmt_next & ~onehot(cmt.stale_0)) | onehot(cmt.prf_0);
        if (cmt_wr_1) cmt_next = (cmt_next & ~onehot(cmt.stale_1)) | onehot(cmt.prf_1);
        cmt_next = cmt_next | BIT0;

        if (recover) begin
            spec_next = cmt_next;  // includes this cycle's commits
        end else begin
            spec_next = ((spec_busy | alloc_mask) & ~free_mask) | BIT0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_busy <= rename_pkg::BUSY_RST;
            cmt_busy  <= rename_pkg::BUSY_RST;
        end else begin
            spec_busy <= spec_next;
            cmt_busy  <= cmt_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/rename_map.sv */
`default_nettype none

module rename_map (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   recover,
    input  wire logic                   pause,
    input  wire logic                   in_valid_0,
    input  wire logic                   in_valid_1,
    input  wire rename_pkg::arch_reg_t  dst_0,
    input  wire rename_pkg::arch_reg_t  dst_1,
    input  wire rename_pkg::arch_reg_t  src1_0,
    input  wire rename_pkg::arch_reg_t  src2_0,
    input  wire rename_pkg::arch_reg_t  src1_1,
    input  wire rename_pkg::arch_reg_t  src2_1,
    output rename_pkg::prf_num_t        src1_prf_0,
    output rename_pkg::prf_num_t        src2_prf_0,
    output rename_pkg::prf_num_t        src1_prf_1,
    output rename_pkg::prf_num_t        src2_prf_1,
    output rename_pkg::prf_num_t        dst_prf_0,
    output rename_pkg::prf_num_t        dst_prf_1,
    output rename_pkg::prf_num_t        stale_prf_0,
    output rename_pkg::prf_num_t        stale_prf_1,
    output logic                        rename_ready,
    alloc_if.requester                  alloc,
    commit_if.sink                      cmt
);

    rename_pkg::prf_num_t spec_map [rename_pkg::ARCH_NUM];
    rename_pkg::prf_num_t cmt_map  [rename_pkg::ARCH_NUM];
    rename_pkg::prf_num_t cmt_next [rename_pkg::ARCH_NUM];

    logic fire;

    // x0 never allocates, so entry 0 stays at physical 0
    assign alloc.req_0 = in_valid_0 && (dst_0 != '0);
    assign alloc.req_1 = in_valid_1 && (dst_1 != '0);

    assign rename_ready = alloc.ready;
    assign fire         = alloc.ready && !pause && !recover;

    assign src1_prf_0 = spec_map[src1_0];
    assign src2_prf_0 = spec_map[src2_0];

    // slot 1 sees slot 0's new mapping
    assign src1_prf_1 = (alloc.req_0 && src1_1 == dst_0) ? alloc.prf_0 : spec_map[src1_1];
    assign src2_prf_1 = (alloc.req_0 && src2_1 == dst_0) ? alloc.prf_0 : spec_map[src2_1];

    assign dst_prf_0 = alloc.req_0 ? alloc.prf_0 : '0;
    assign dst_prf_1 = alloc.req_1 ? alloc.prf_1 : '0;

    assign stale_prf_0 = alloc.req_0 ? spec_map[dst_0] : '0;

    always_comb begin
        if (!alloc.req_1) begin
            stale_prf_1 = '0;
        end else if (alloc.req_0 && dst_1 == dst_0) begin
            stale_prf_1 = alloc.prf_0;  // same destination inside the group
        end else begin
            stale_prf_1 = spec_map[dst_1];
        end
    end

    // committed table after this cycle's commits, younger slot last
    always_comb begin
        cmt_next = cmt_map;
        if (cmt.valid_0 && cmt.wr_0 && cmt.arch_0 != '0) cmt_next[cmt.arch_0] = cmt.prf_0;
        if (cmt.valid_1 && cmt.wr_1 && cmt.arch_1 != '0) cmt_next[cmt.arch_1] = cmt.prf_1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARCH_NUM; i++) begin
                spec_map[i] <= rename_pkg::prf_num_t'(i);  // identity
                cmt_map[i]  <= rename_pkg::prf_num_t'(i);
            end
        end else begin
            cmt_map <= cmt_next;
            if (recover) begin
                spec_map <= cmt_next;
            end else if (fire) begin
                if (alloc.req_0) spec_map[dst_0] <= alloc.prf_0;
                if (alloc.req_1) spec_map[dst_1] <= alloc.prf_1;  // slot 1 wins
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/rename_stage.sv */
`default_nettype none

module rename_stage (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   recover,
    input  wire logic                   pause,
    // rename slot 0
    input  wire logic                   in_valid_0,
    input  wire rename_pkg::arch_reg_t  dst_0,
    input  wire rename_pkg::arch_reg_t  src1_0,
    input  wire rename_pkg::arch_reg_t  src2_0,
    output rename_pkg::prf_num_t        src1_prf_0,
    output rename_pkg::prf_num_t        src2_prf_0,
    output rename_pkg::prf_num_t        dst_prf_0,
    output rename_pkg::prf_num_t        stale_prf_0,
    // rename slot 1
    input  wire logic                   in_valid_1,
    input  wire rename_pkg::arch_reg_t  dst_1,
    input  wire rename_pkg::arch_reg_t  src1_1,
    input  wire rename_pkg::arch_reg_t  src2_1,
    output rename_pkg::prf_num_t        src1_prf_1,
    output rename_pkg::prf_num_t        src2_prf_1,
    output rename_pkg::prf_num_t        dst_prf_1,
    output rename_pkg::prf_num_t        stale_prf_1,
    output logic                        rename_ready,
    // commit
    input  wire logic                   commit_valid_0,
    input  wire logic                   commit_wr_0,
    input  wire rename_pkg::arch_reg_t  commit_arch_0,
    input  wire rename_pkg::prf_num_t   commit_prf_0,
    input  wire rename_pkg::prf_num_t   commit_stale_0,
    input  wire logic                   commit_valid_1,
    input  wire logic                   commit_wr_1,
    input  wire rename_pkg::arch_reg_t  commit_arch_1,
    input  wire rename_pkg::prf_num_t   commit_prf_1,
    input  wire rename_pkg::prf_num_t   commit_stale_1
);

    alloc_if  alloc ();
    commit_if cmt ();

    assign cmt.valid_0 = commit_valid_0;
    assign cmt.wr_0    = commit_wr_0;
    assign cmt.arch_0  = commit_arch_0;
    assign cmt.prf_0   = commit_prf_0;
    assign cmt.stale_0 = commit_stale_0;
    assign cmt.valid_1 = commit_valid_1;
    assign cmt.wr_1    = commit_wr_1;
    assign cmt.arch_1  = commit_arch_1;
    assign cmt.prf_1   = commit_prf_1;
    assign cmt.stale_1 = commit_stale_1;

    rename_map i_map (
        .clk          (clk),
        .rst          (rst),
        .recover      (recover),
        .pause        (pause),
        .in_valid_0   (in_valid_0),
        .in_valid_1   (in_valid_1),
        .dst_0        (dst_0),
        .dst_1        (dst_1),
        .src1_0       (src1_0),
        .src2_0       (src2_0),
        .src1_1       (src1_1),
        .src2_1       (src2_1),
        .src1_prf_0   (src1_prf_0),
        .src2_prf_0   (src2_prf_0),
        .src1_prf_1   (src1_prf_1),
        .src2_prf_1   (src2_prf_1),
        .dst_prf_0    (dst_prf_0),
        .dst_prf_1    (dst_prf_1),
        .stale_prf_0  (stale_prf_0),
        .stale_prf_1  (stale_prf_1),
        .rename_ready (rename_ready),
        .alloc        (alloc.requester),
        .cmt          (cmt.sink)
    );

    free_list i_free_list (
        .clk     (clk),
        .rst     (rst),
        .recover (recover),
        .pause   (pause),
        .alloc   (alloc.provider),
        .cmt     (cmt.sink)
    );

endmodule

`default_nettype wire

/* dv/rename_tb.sv */
`default_nettype none

module rename_tb;

    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RANDOM_CYCLES   = 200;

    typedef rename_pkg::arch_reg_t arch_t;
    typedef rename_pkg::prf_num_t  prf_t;

    // one renamed instruction waiting for commit
    typedef struct packed {
        logic  wr;
        arch_t arch;
        prf_t  prf;
        prf_t  stale;
    } pend_t;

    logic  clk, rst, recover, pause;
    logic  in_valid_0, in_valid_1, rename_ready;
    arch_t dst_0, src1_0, src2_0, dst_1, src1_1, src2_1;
    prf_t  src1_prf_0, src2_prf_0, dst_prf_0, stale_prf_0;
    prf_t  src1_prf_1, src2_prf_1, dst_prf_1, stale_prf_1;
    logic  commit_valid_0, commit_wr_0, commit_valid_1, commit_wr_1;
    arch_t commit_arch_0, commit_arch_1;
    prf_t  commit_prf_0, commit_stale_0, commit_prf_1, commit_stale_1;

    // reference model state
    prf_t                           m_spec [rename_pkg::ARCH_NUM];
    prf_t                           m_cmt  [rename_pkg::ARCH_NUM];
    logic [rename_pkg::PRF_NUM-1:0] m_sbusy, m_cbusy;
    pend_t                          pend [256];
    logic [7:0]                     wr_ptr, rd_ptr;  // ring of in-flight instructions
    logic [15:0]                    lfsr;

    logic req_0, req_1, exp_ready;
    prf_t exp_dst_0, exp_dst_1, exp_stale_0, exp_stale_1, exp_src1_1, exp_src2_1;

    rename_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // index of the n-th clear bit, counting from 0 upward
    function automatic prf_t nth_free(input logic [rename_pkg::PRF_NUM-1:0] busy, input int n);
        int   seen;
        prf_t idx;
        seen = 0;
        idx  = 6'd0;
        for (int i = 0; i < rename_pkg::PRF_NUM; i++) begin
            if (!busy[i]) begin
                if (seen == n) idx = prf_t'(i);
                seen++;
            end
        end
        return idx;
    endfunction

    always_comb begin
        req_0       = in_valid_0 && dst_0 != 5'd0;
        req_1       = in_valid_1 && dst_1 != 5'd0;
        exp_ready   = $countones(~m_sbusy) >= (req_0 ? 1 : 0) + (req_1 ? 1 : 0);
        exp_dst_0   = req_0 ? nth_free(m_sbusy, 0) : 6'd0;
        exp_dst_1   = req_1 ? nth_free(m_sbusy, req_0 ? 1 : 0) : 6'd0;
        exp_src1_1  = (req_0 && src1_1 == dst_0) ? exp_dst_0 : m_spec[src1_1];
        exp_src2_1  = (req_0 && src2_1 == dst_0) ? exp_dst_0 : m_spec[src2_1];
        exp_stale_0 = req_0 ? m_spec[dst_0] : 6'd0;
        if (!req_1) exp_stale_1 = 6'd0;
        else if (req_0 && dst_1 == dst_0) exp_stale_1 = exp_dst_0;  // same destination
        else exp_stale_1 = m_spec[dst_1];
    end

    always @(posedge clk) begin : model
        prf_t                           nc [rename_pkg::ARCH_NUM];
        logic [rename_pkg::PRF_NUM-1:0] ncb;
        logic [rename_pkg::PRF_NUM-1:0] sb;
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARCH_NUM; i++) begin
                m_spec[i] <= prf_t'(i);
                m_cmt[i]  <= prf_t'(i);
            end
            m_sbusy <= 64'h0000_0000_ffff_ffff;
            m_cbusy <= 64'h0000_0000_ffff_ffff;
            wr_ptr  <= 8'd0;
        end else begin
            nc  = m_cmt;
            ncb = m_cbusy;
            sb  = m_sbusy;
            if (commit_valid_0 && commit_wr_0) begin  // older slot first
                nc[commit_arch_0]   = commit_prf_0;
                ncb[commit_stale_0] = 1'b0;
                ncb[commit_prf_0]   = 1'b1;
                sb[commit_stale_0]  = 1'b0;
            end
            if (commit_valid_1 && commit_wr_1) begin
                nc[commit_arch_1]   = commit_prf_1;
                ncb[commit_stale_1] = 1'b0;
                ncb[commit_prf_1]   = 1'b1;
                sb[commit_stale_1]  = 1'b0;
            end
            m_cmt   <= nc;
            m_cbusy <= ncb;
            if (recover) begin
                m_spec  <= nc;
                m_sbusy <= ncb;
                wr_ptr  <= rd_ptr;  // drop everything not committed
            end else begin
                if (exp_ready && !pause) begin
                    if (req_0) m_spec[dst_0] <= exp_dst_0;
                    if (req_1) m_spec[dst_1] <= exp_dst_1;
                    if (req_0) sb[exp_dst_0] = 1'b1;
                    if (req_1) sb[exp_dst_1] = 1'b1;
                    if (in_valid_0) pend[wr_ptr] <= {req_0, dst_0, exp_dst_0, exp_stale_0};
                    if (in_valid_1) begin
                        pend[wr_ptr + 8'(in_valid_0)] <= {req_1, dst_1, exp_dst_1, exp_stale_1};
                    end
                    wr_ptr <= wr_ptr + 8'(in_valid_0) + 8'(in_valid_1);
                end
                m_sbusy <= sb;
            end
        end
    end

    task automatic report_mismatch(input string name, input prf_t exp_v, input prf_t act_v);
        $display("ERR %s expected %h actual %h", name, exp_v, act_v);
        $display("Something failed");
        $fatal(1);
    endtask

    a_ready: assert property (@(posedge clk) disable iff (rst) rename_ready == exp_ready)
        else report_mismatch("rename_ready", prf_t'($sampled(exp_ready)),
                             prf_t'($sampled(rename_ready)));
    a_src1_0: assert property (@(posedge clk) disable iff (rst) src1_prf_0 == m_spec[src1_0])
        else report_mismatch("src1_prf_0", $sampled(m_spec[src1_0]), $sampled(src1_prf_0));
    a_src2_0: assert property (@(posedge clk) disable iff (rst) src2_prf_0 == m_spec[src2_0])
        else report_mismatch("src2_prf_0", $sampled(m_spec[src2_0]), $sampled(src2_prf_0));
    a_stale_0: assert property (@(posedge clk) disable iff (rst) stale_prf_0 == exp_stale_0)
        else report_mismatch("stale_prf_0", $sampled(exp_stale_0), $sampled(stale_prf_0));
    a_dst_0: assert property (@(posedge clk) disable iff (rst) dst_prf_0 == exp_dst_0)
        else report_mismatch("dst_prf_0", $sampled(exp_dst_0), $sampled(dst_prf_0));
    a_dst_1: assert property (@(posedge clk) disable iff (rst) dst_prf_1 == exp_dst_1)
        else report_mismatch("dst_prf_1", $sampled(exp_dst_1), $sampled(dst_prf_1));
    a_src1_1: assert property (@(posedge clk) disable iff (rst) src1_prf_1 == exp_src1_1)
        else report_mismatch("src1_prf_1", $sampled(exp_src1_1), $sampled(src1_prf_1));
    a_src2_1: assert property (@(posedge clk) disable iff (rst) src2_prf_1 == exp_src2_1)
        else report_mismatch("src2_prf_1", $sampled(exp_src2_1), $sampled(src2_prf_1));
    a_stale_1: assert property (@(posedge clk) disable iff (rst) stale_prf_1 == exp_stale_1)
        else report_mismatch("stale_prf_1", $sampled(exp_stale_1), $sampled(stale_prf_1));

    task automatic drive_rename(input logic v0, input arch_t d0, input arch_t s10, input arch_t s20,
                                input logic v1, input arch_t d1, input arch_t s11, input arch_t s21);
        in_valid_0 <= v0;
        dst_0      <= d0;
        src1_0     <= s10;
        src2_0     <= s20;
        in_valid_1 <= v1;
        dst_1      <= d1;
        src1_1     <= s11;
        src2_1     <= s21;
    endtask

    // next edge, then pause/recover and up to two in-order commits from the ring
    task automatic next_cycle(input logic p, input logic r, input int n_cmt);
        int n;
        @(posedge clk);
        n = recover ? 0 : n_cmt;  // squashed entries never commit
        if (n > 2) n = 2;
        if (n > int'(wr_ptr - rd_ptr)) n = int'(wr_ptr - rd_ptr);
        pause          <= p;
        recover        <= r;
        commit_valid_0 <= n > 0;
        commit_wr_0    <= pend[rd_ptr].wr;
        commit_arch_0  <= pend[rd_ptr].arch;
        commit_prf_0   <= pend[rd_ptr].prf;
        commit_stale_0 <= pend[rd_ptr].stale;
        commit_valid_1 <= n > 1;
        commit_wr_1    <= pend[rd_ptr + 8'd1].wr;
        commit_arch_1  <= pend[rd_ptr + 8'd1].arch;
        commit_prf_1   <= pend[rd_ptr + 8'd1].prf;
        commit_stale_1 <= pend[rd_ptr + 8'd1].stale;
        rd_ptr         <= rd_ptr + 8'(n);
    endtask

    initial begin : stimulus
        logic [31:0] ra;
        logic [31:0] rb;
        lfsr    = 16'd95;
        rst     <= 1'b1;
        pause   <= 1'b0;
        recover <= 1'b0;
        rd_ptr  <= 8'd0;
        {commit_valid_0, commit_wr_0, commit_arch_0, commit_prf_0, commit_stale_0} <= '0;
        {commit_valid_1, commit_wr_1, commit_arch_1, commit_prf_1, commit_stale_1} <= '0;
        drive_rename(0, 0, 0, 0, 0, 0, 0, 0);
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        drive_rename(1, 1, 0, 0, 1, 2, 1, 0);  // lowest two free, 32 and 33
        next_cycle(0, 0, 0);
        drive_rename(1, 3, 1, 2, 1, 3, 3, 1);  // bypass and same destination
        next_cycle(0, 0, 0);
        drive_rename(1, 0, 0, 3, 1, 5, 0, 3);  // x0 destination
        next_cycle(0, 0, 2);
        drive_rename(0, 0, 0, 0, 0, 0, 0, 0);
        repeat (3) next_cycle(0, 0, 2);
        // no commits, so the free list runs dry and the group stalls
        for (int i = 0; i < 20; i++) begin
            next_cycle(0, 0, 0);
            drive_rename(1, arch_t'(i + 1), arch_t'(i), 1, 1, arch_t'(i + 8), arch_t'(i + 1), 2);
        end
        repeat (4) next_cycle(1, 0, 2);  // paused, commits still free registers
        repeat (2) next_cycle(0, 0, 0);
        next_cycle(0, 0, 2);
        drive_rename(1, 7, 1, 2, 1, 9, 7, 9);
        next_cycle(0, 1, 2);  // recover together with a commit
        drive_rename(1, 4, 4, 9, 1, 6, 7, 1);
        repeat (2) next_cycle(0, 0, 0);
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            ra = rand_bits(27);
            rb = rand_bits(15);
            next_cycle(ra[2:0] == 3'd0, ra[7:3] == 5'd0, int'(ra[9:8]));
            drive_rename(ra[10], ra[15:11], ra[20:16], ra[25:21],
                         ra[26], rb[4:0], rb[9:5], rb[14:10]);
        end
        next_cycle(0, 0, 0);
        @(posedge clk);
        @(negedge clk);
        $display("Everything OK");
        $finish;
    end

    initial begin : watchdog
        #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50) * 8);
        $display("timeout, the stimulus did not reach its end in time");
        $display("Something failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/rename_pkg.sv
rtl/alloc_if.sv
rtl/commit_if.sv
rtl/prf_free_enc.sv
rtl/free_list.sv
rtl/rename_map.sv
rtl/rename_stage.sv
dv/rename_tb.sv

/* Makefile */
TOP := rename_tb

sim:
	verilator --binary --assert -f verilog.f --top-module $(TOP) -o rename_sim
	out=$$(./obj_dir/rename_sim); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean
